// ==== source/dsi3_params.svh ====
// Widths, FIFO depth and register map of the DSI3 receiver
// FIFO depth must be a power of two; register offsets are byte addresses
`ifndef DSI3_PARAMS_SVH
`define DSI3_PARAMS_SVH

`define DSI3_DATA_WIDTH 16
`define DSI3_ECC_WIDTH 6
`define DSI3_SYMBOL_WIDTH 4
`define DSI3_COUNT_WIDTH 9
`define DSI3_FIFO_DEPTH 8
`define DSI3_TIMEOUT_WIDTH 16

`define DSI3_AXIL_ADDR_WIDTH 8
`define DSI3_AXIL_DATA_WIDTH 32
`define DSI3_ADDR_CTRL 8'h00
`define DSI3_ADDR_TIMEOUT 8'h04
`define DSI3_ADDR_STATUS 8'h08
`define DSI3_ADDR_DATA 8'h0C
`define DSI3_ADDR_INFO 8'h10

`endif

// ==== source/dsi3_pkg.sv ====
// Shared types of the DSI3 receive path
// Widths come from the parameter header
`default_nettype none

`include "dsi3_params.svh"

package dsi3_pkg;

	typedef logic [`DSI3_SYMBOL_WIDTH-1:0] symbol_t;
	typedef logic [`DSI3_DATA_WIDTH-1:0] data_t;
	typedef logic [`DSI3_ECC_WIDTH-1:0] ecc_t;
	typedef logic [`DSI3_COUNT_WIDTH-1:0] symbol_count_t;
	typedef logic [`DSI3_TIMEOUT_WIDTH-1:0] timeout_t;

	// Receive control FSM
	typedef enum logic [1:0] {RX_IDLE, RX_PENDING, RX_DONE} rx_state_t;

endpackage

`default_nettype wire

// ==== source/dsi3_word_if.sv ====
// One finished word with its check bits and response position
// valid is a single-cycle strobe with no back-pressure
`timescale 1ns/1ps
`default_nettype none

interface dsi3_word_if;
	import dsi3_pkg::*;

	logic valid;
	data_t data;
	ecc_t ecc;
	symbol_count_t symbol_count;
	logic overflow;

	modport source (output valid, data, ecc, symbol_count, overflow);
	modport sink (input valid, data, ecc, symbol_count, overflow);

endinterface

`default_nettype wire

// ==== source/ecc_encoder.sv ====
// SEC-DED check bits for one data word, purely combinational
// Data bit 0 sits at codeword position 3, then upward past 4, 8 and 16
// o_ecc[4:0] are the Hamming bits at positions 1,2,4,8,16, o_ecc[5] overall parity
`timescale 1ns/1ps
`default_nettype none

`include "dsi3_params.svh"

module ecc_encoder (
	input wire dsi3_pkg::data_t i_data,
	output dsi3_pkg::ecc_t o_ecc
);

	localparam int HAMMING_BITS = `DSI3_ECC_WIDTH - 1;
	localparam int CODE_WIDTH = `DSI3_DATA_WIDTH + HAMMING_BITS;

	logic [CODE_WIDTH:1] code;
	logic [HAMMING_BITS-1:0] hamming;

	always_comb begin
		int d;
		d = 0;
		code = '0;
		hamming = '0;
		// Data fills every position that is not a power of two
		for (int pos = 1; pos <= CODE_WIDTH; pos++) begin
			if ((pos & (pos - 1)) != 0) begin
				code[pos] = i_data[d];
				d++;
			end
		end
		for (int pos = 1; pos <= CODE_WIDTH; pos++) begin
			for (int k = 0; k < HAMMING_BITS; k++) begin
				if (((pos >> k) & 1) != 0) begin
					hamming[k] = hamming[k] ^ code[pos];
				end
			end
		end
	end

	assign o_ecc = {(^i_data) ^ (^hamming), hamming};

endmodule

`default_nettype wire

// ==== source/dsi3_receive_control.sv ====
// Response FSM and symbol gap timer
// i_timeout must be nonzero, a zero limit ends a response at once
`timescale 1ns/1ps
`default_nettype none

module dsi3_receive_control (
	input wire clk_rst,
	input wire i_rst_n,
	input wire i_enable,
	input wire i_start,
	input wire dsi3_pkg::timeout_t i_timeout,
	input wire i_symbol_valid,
	input wire i_stop_receiving,
	output logic o_started_tick,
	output logic o_time_out,
	output logic o_rec_pending,
	output logic o_busy
);
	import dsi3_pkg::*;

	rx_state_t state, state_next;
	timeout_t gap_cnt;

	always_comb begin
		state_next = state;
		case (state)
			RX_IDLE: if (i_start && i_enable) state_next = RX_PENDING;
			RX_PENDING: if (i_stop_receiving || !i_enable) state_next = RX_DONE;
			default: state_next = RX_IDLE;
		endcase
	end

	always_ff @(posedge clk_rst) begin
		if (!i_rst_n) begin
			state <= RX_IDLE;
			o_started_tick <= 1'b0;
			gap_cnt <= '0;
		end else begin
			state <= state_next;
			o_started_tick <= (state == RX_IDLE) && (state_next == RX_PENDING);
			// Reload on every symbol, hold at the limit
			if ((state != RX_PENDING) || i_symbol_valid)
				gap_cnt <= '0;
			else if (gap_cnt < i_timeout)
				gap_cnt <= gap_cnt + timeout_t'(1);
		end
	end

	assign o_time_out = (state == RX_PENDING) && (gap_cnt >= i_timeout);
	assign o_rec_pending = (state == RX_PENDING);
	assign o_busy = (state != RX_IDLE);

	a_tick_on_start: assert property (@(posedge clk_rst) disable iff (!i_rst_n)
		o_started_tick |-> (state == RX_PENDING) && ($past(state) == RX_IDLE));

endmodule

`default_nettype wire

// ==== source/dsi3_receive_data_collect.sv ====
// Packs symbols into words, MSB nibble first, and adds check bits
// Only words ending at symbol 4..256 are stored; the end pulse follows the last strobe
// The symbol count is cleared only by the start tick or by disable
`timescale 1ns/1ps
`default_nettype none

module dsi3_receive_data_collect (
	input wire clk_rst,
	input wire i_rst_n,
	input wire i_symbol_ready,
	input wire dsi3_pkg::symbol_t i_symbol,
	input wire i_response_finished,
	input wire i_receiving_started_tick,
	input wire i_enable_receiver,
	input wire i_receive_time_out,
	input wire i_rec_pending,
	output logic o_stop_receiving,
	output logic o_response_done,
	output dsi3_pkg::symbol_count_t o_last_count,
	output logic o_last_overflow,
	dsi3_word_if.source o_word
);
	import dsi3_pkg::*;

	localparam symbol_count_t MIN_WORD_COUNT = symbol_count_t'(4);
	localparam symbol_count_t MAX_WORD_COUNT = symbol_count_t'(256);
	localparam symbol_count_t OVERFLOW_LIMIT = symbol_count_t'(255);

	symbol_count_t count, count_next;
	data_t word, word_next, word_sel;
	ecc_t ecc_sel;
	logic response_end, word_full, word_partial, store;

	always_comb begin
		word_next = word;
		case (count[1:0])
			2'd0: word_next = {i_symbol, 12'h000};
			2'd1: word_next[11:8] = i_symbol;
			2'd2: word_next[7:4] = i_symbol;
			default: word_next[3:0] = i_symbol;
		endcase
	end

	// Saturating symbol counter
	always_comb begin
		count_next = count;
		if (i_symbol_ready && (count != '1))
			count_next = count + symbol_count_t'(1);
		if (i_receiving_started_tick || !i_enable_receiver)
			count_next = '0;
	end

	assign response_end = i_response_finished || (i_receive_time_out && i_rec_pending);
	assign o_stop_receiving = response_end;

	assign word_full = i_symbol_ready && (count[1:0] == 2'd3);
	// Leftover nibbles at the end of a response
	assign word_partial = response_end && (count[1:0] != 2'd0) && !word_full;
	assign store = (word_full || word_partial)
		&& (count_next >= MIN_WORD_COUNT) && (count_next <= MAX_WORD_COUNT);
	assign word_sel = word_full ? word_next : word;

	ecc_encoder ecc_encoder_i (
		.i_data (word_sel),
		.o_ecc  (ecc_sel)
	);

	always_ff @(posedge clk_rst) begin
		if (!i_rst_n) begin
			count <= '0;
			o_word.valid <= 1'b0;
			o_response_done <= 1'b0;
			o_last_count <= '0;
			o_last_overflow <= 1'b0;
		end else begin
			count <= count_next;
			o_word.valid <= store;
			o_response_done <= response_end;
			if (response_end) begin
				o_last_count <= count;
				o_last_overflow <= (count > OVERFLOW_LIMIT);
			end
		end
	end

	always_ff @(posedge clk_rst) begin
		if (i_symbol_ready)
			word <= word_next;
		if (store) begin
			o_word.data <= word_sel;
			o_word.ecc <= ecc_sel;
			o_word.symbol_count <= count_next;
			o_word.overflow <= (count_next > OVERFLOW_LIMIT);
		end
	end

	a_word_count: assert property (@(posedge clk_rst) disable iff (!i_rst_n)
		o_word.valid |-> (count >= MIN_WORD_COUNT));

endmodule

`default_nettype wire

// ==== source/dsi3_rx_fifo.sv ====
// Word FIFO, head entry shown combinationally
// A write while full is lost and sets o_dropped until i_clear_drop
`timescale 1ns/1ps
`default_nettype none

`include "dsi3_params.svh"

module dsi3_rx_fifo (
	input wire clk_rst,
	input wire i_rst_n,
	dsi3_word_if.sink i_word,
	input wire i_pop,
	input wire i_clear_drop,
	output dsi3_pkg::data_t o_data,
	output dsi3_pkg::ecc_t o_ecc,
	output dsi3_pkg::symbol_count_t o_count,
	output logic o_overflow,
	output logic o_empty,
	output logic [$clog2(`DSI3_FIFO_DEPTH):0] o_level,
	output logic o_dropped
);
	import dsi3_pkg::*;

	localparam int PTR_WIDTH = $clog2(`DSI3_FIFO_DEPTH);
	typedef logic [PTR_WIDTH-1:0] ptr_t;
	typedef logic [PTR_WIDTH:0] level_t;

	data_t mem_data [`DSI3_FIFO_DEPTH];
	ecc_t mem_ecc [`DSI3_FIFO_DEPTH];
	symbol_count_t mem_count [`DSI3_FIFO_DEPTH];
	logic mem_overflow [`DSI3_FIFO_DEPTH];
	ptr_t wr_ptr, rd_ptr;
	logic full, push, pop;

	assign full = (o_level == level_t'(`DSI3_FIFO_DEPTH));
	assign o_empty = (o_level == '0);
	assign push = i_word.valid && !full;
	assign pop = i_pop && !o_empty;

	always_ff @(posedge clk_rst) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			o_level <= '0;
			o_dropped <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + ptr_t'(1);
			if (pop)
				rd_ptr <= rd_ptr + ptr_t'(1);
			if (push && !pop)
				o_level <= o_level + level_t'(1);
			else if (pop && !push)
				o_level <= o_level - level_t'(1);
			if (i_word.valid && full)
				o_dropped <= 1'b1;
			else if (i_clear_drop)
				o_dropped <= 1'b0;
		end
	end

	always_ff @(posedge clk_rst) begin
		if (push) begin
			mem_data[wr_ptr] <= i_word.data;
			mem_ecc[wr_ptr] <= i_word.ecc;
			mem_count[wr_ptr] <= i_word.symbol_count;
			mem_overflow[wr_ptr] <= i_word.overflow;
		end
	end

	assign o_data = mem_data[rd_ptr];
	assign o_ecc = mem_ecc[rd_ptr];
	assign o_count = mem_count[rd_ptr];
	assign o_overflow = mem_overflow[rd_ptr];

	a_no_pop_empty: assert property (@(posedge clk_rst) disable iff (!i_rst_n)
		i_pop |-> !o_empty);

endmodule

`default_nettype wire

// ==== source/dsi3_axil_regs.sv ====
// AXI4-Lite register slave, one outstanding read and one outstanding write
// Reading DATA pops the FIFO; reading it while empty returns zero
// STATUS bit 7 is sticky and cleared by a STATUS read
`timescale 1ns/1ps
`default_nettype none

`include "dsi3_params.svh"

module dsi3_axil_regs (
	input wire clk_rst,
	input wire i_rst_n,
	input wire [`DSI3_AXIL_ADDR_WIDTH-1:0] i_axil_awaddr,
	input wire i_axil_awvalid,
	output logic o_axil_awready,
	input wire [`DSI3_AXIL_DATA_WIDTH-1:0] i_axil_wdata,
	input wire [`DSI3_AXIL_DATA_WIDTH/8-1:0] i_axil_wstrb,
	input wire i_axil_wvalid,
	output logic o_axil_wready,
	output logic [1:0] o_axil_bresp,
	output logic o_axil_bvalid,
	input wire i_axil_bready,
	input wire [`DSI3_AXIL_ADDR_WIDTH-1:0] i_axil_araddr,
	input wire i_axil_arvalid,
	output logic o_axil_arready,
	output logic [`DSI3_AXIL_DATA_WIDTH-1:0] o_axil_rdata,
	output logic [1:0] o_axil_rresp,
	output logic o_axil_rvalid,
	input wire i_axil_rready,
	input wire dsi3_pkg::data_t i_rd_data,
	input wire dsi3_pkg::ecc_t i_rd_ecc,
	input wire dsi3_pkg::symbol_count_t i_rd_count,
	input wire i_rd_overflow,
	input wire i_empty,
	input wire [$clog2(`DSI3_FIFO_DEPTH):0] i_level,
	input wire i_dropped,
	input wire dsi3_pkg::symbol_count_t i_last_count,
	input wire i_last_overflow,
	input wire i_response_done,
	input wire i_busy,
	output logic o_enable,
	output logic o_start,
	output dsi3_pkg::timeout_t o_timeout,
	output logic o_pop,
	output logic o_clear_drop
);
	import dsi3_pkg::*;

	localparam int STRB_WIDTH = `DSI3_AXIL_DATA_WIDTH / 8;
	localparam timeout_t TIMEOUT_RESET = timeout_t'(1000);
	typedef logic [`DSI3_AXIL_ADDR_WIDTH-1:0] addr_t;
	typedef logic [`DSI3_AXIL_DATA_WIDTH-1:0] bus_word_t;

	logic ready_en, aw_held, w_held, aw_hs, w_hs, ar_hs, do_write, resp_done_sticky;
	addr_t aw_addr, wr_addr;
	bus_word_t w_data, wr_data, rd_mux;
	logic [STRB_WIDTH-1:0] w_strb, wr_strb;

	// Readies stay low for the first cycle out of reset
	assign o_axil_awready = ready_en && !aw_held && !o_axil_bvalid;
	assign o_axil_wready = ready_en && !w_held && !o_axil_bvalid;
	assign o_axil_arready = ready_en && !o_axil_rvalid;
	assign aw_hs = i_axil_awvalid && o_axil_awready;
	assign w_hs = i_axil_wvalid && o_axil_wready;
	assign ar_hs = i_axil_arvalid && o_axil_arready;
	assign do_write = (aw_held || aw_hs) && (w_held || w_hs);
	assign wr_addr = aw_held ? aw_addr : i_axil_awaddr;
	assign wr_data = w_held ? w_data : i_axil_wdata;
	assign wr_strb = w_held ? w_strb : i_axil_wstrb;
	assign o_axil_bresp = 2'b00;
	assign o_axil_rresp = 2'b00;
	assign o_pop = ar_hs && (i_axil_araddr == `DSI3_ADDR_DATA) && !i_empty;

	always_ff @(posedge clk_rst) begin
		if (!i_rst_n) begin
			ready_en <= 1'b0;
			aw_held <= 1'b0;
			w_held <= 1'b0;
			o_axil_bvalid <= 1'b0;
			o_axil_rvalid <= 1'b0;
			resp_done_sticky <= 1'b0;
		end else begin
			ready_en <= 1'b1;
			if (do_write) begin
				aw_held <= 1'b0;
				w_held <= 1'b0;
				o_axil_bvalid <= 1'b1;
			end else begin
				if (aw_hs)
					aw_held <= 1'b1;
				if (w_hs)
					w_held <= 1'b1;
				if (o_axil_bvalid && i_axil_bready)
					o_axil_bvalid <= 1'b0;
			end
			if (ar_hs)
				o_axil_rvalid <= 1'b1;
			else if (i_axil_rready)
				o_axil_rvalid <= 1'b0;
			if (i_response_done)
				resp_done_sticky <= 1'b1;
			else if (ar_hs && (i_axil_araddr == `DSI3_ADDR_STATUS))
				resp_done_sticky <= 1'b0;
		end
	end

	always_ff @(posedge clk_rst) begin
		if (aw_hs)
			aw_addr <= i_axil_awaddr;
		if (w_hs) begin
			w_data <= i_axil_wdata;
			w_strb <= i_axil_wstrb;
		end
		if (ar_hs)
			o_axil_rdata <= rd_mux;
	end

	// Start and drop clear are single-cycle pulses
	always_ff @(posedge clk_rst) begin
		if (!i_rst_n) begin
			o_enable <= 1'b0;
			o_start <= 1'b0;
			o_clear_drop <= 1'b0;
			o_timeout <= TIMEOUT_RESET;
		end else begin
			o_start <= 1'b0;
			o_clear_drop <= 1'b0;
			if (do_write && (wr_addr == `DSI3_ADDR_CTRL) && wr_strb[0]) begin
				o_enable <= wr_data[0];
				o_start <= wr_data[1];
				o_clear_drop <= wr_data[2];
			end
			if (do_write && (wr_addr == `DSI3_ADDR_TIMEOUT)) begin
				for (int b = 0; b < `DSI3_TIMEOUT_WIDTH / 8; b++) begin
					if (wr_strb[b])
						o_timeout[b*8 +: 8] <= wr_data[b*8 +: 8];
				end
			end
		end
	end

	always_comb begin
		rd_mux = '0;
		case (i_axil_araddr)
			`DSI3_ADDR_CTRL: rd_mux[0] = o_enable;
			`DSI3_ADDR_TIMEOUT: rd_mux[`DSI3_TIMEOUT_WIDTH-1:0] = o_timeout;
			`DSI3_ADDR_STATUS: begin
				rd_mux[0] = i_empty;
				rd_mux[4:1] = i_level;
				rd_mux[5] = i_dropped;
				rd_mux[6] = i_busy;
				rd_mux[7] = resp_done_sticky;
				rd_mux[24:16] = i_last_count;
				rd_mux[25] = i_last_overflow;
			end
			`DSI3_ADDR_DATA: begin
				if (!i_empty) begin
					rd_mux[15:0] = i_rd_data;
					rd_mux[21:16] = i_rd_ecc;
				end
			end
			// Head entry, no pop
			`DSI3_ADDR_INFO: begin
				rd_mux[8:0] = i_rd_count;
				rd_mux[9] = i_rd_overflow;
			end
			default: rd_mux = '0;
		endcase
	end

	a_rvalid_hold: assert property (@(posedge clk_rst) disable iff (!i_rst_n)
		o_axil_rvalid && !i_axil_rready |=> o_axil_rvalid && $stable(o_axil_rdata));

endmodule

`default_nettype wire

// ==== source/dsi3_receiver_top.sv ====
// DSI3 receive path with AXI4-Lite register access
// Symbols are never stalled; words are lost once the FIFO is full
`timescale 1ns/1ps
`default_nettype none

`include "dsi3_params.svh"

module dsi3_receiver_top (
	input wire clk_rst,
	input wire i_rst_n,
	input wire i_symbol_valid,
	input wire dsi3_pkg::symbol_t i_symbol,
	input wire i_response_end,
	input wire [`DSI3_AXIL_ADDR_WIDTH-1:0] s_axil_awaddr,
	input wire s_axil_awvalid,
	output logic s_axil_awready,
	input wire [`DSI3_AXIL_DATA_WIDTH-1:0] s_axil_wdata,
	input wire [`DSI3_AXIL_DATA_WIDTH/8-1:0] s_axil_wstrb,
	input wire s_axil_wvalid,
	output logic s_axil_wready,
	output logic [1:0] s_axil_bresp,
	output logic s_axil_bvalid,
	input wire s_axil_bready,
	input wire [`DSI3_AXIL_ADDR_WIDTH-1:0] s_axil_araddr,
	input wire s_axil_arvalid,
	output logic s_axil_arready,
	output logic [`DSI3_AXIL_DATA_WIDTH-1:0] s_axil_rdata,
	output logic [1:0] s_axil_rresp,
	output logic s_axil_rvalid,
	input wire s_axil_rready
);
	import dsi3_pkg::*;

	logic started_tick, time_out, rec_pending, enable, start, busy, stop_receiving;
	logic rd_overflow, empty, dropped, pop, clear_drop, last_overflow, response_done;
	data_t rd_data;
	ecc_t rd_ecc;
	symbol_count_t rd_count, last_count;
	timeout_t timeout;
	logic [$clog2(`DSI3_FIFO_DEPTH):0] level;

	dsi3_word_if word_if ();

	dsi3_receive_control dsi3_receive_control_i (
		.clk_rst (clk_rst), .i_rst_n (i_rst_n),
		.i_enable (enable), .i_start (start), .i_timeout (timeout),
		.i_symbol_valid (i_symbol_valid), .i_stop_receiving (stop_receiving),
		.o_started_tick (started_tick), .o_time_out (time_out),
		.o_rec_pending (rec_pending), .o_busy (busy)
	);

	dsi3_receive_data_collect dsi3_receive_data_collect_i (
		.clk_rst (clk_rst), .i_rst_n (i_rst_n),
		.i_symbol_ready (i_symbol_valid), .i_symbol (i_symbol),
		.i_response_finished (i_response_end), .i_receiving_started_tick (started_tick),
		.i_enable_receiver (enable), .i_receive_time_out (time_out),
		.i_rec_pending (rec_pending), .o_stop_receiving (stop_receiving),
		.o_response_done (response_done), .o_last_count (last_count),
		.o_last_overflow (last_overflow), .o_word (word_if.source)
	);

	dsi3_rx_fifo dsi3_rx_fifo_i (
		.clk_rst (clk_rst), .i_rst_n (i_rst_n), .i_word (word_if.sink),
		.i_pop (pop), .i_clear_drop (clear_drop),
		.o_data (rd_data), .o_ecc (rd_ecc), .o_count (rd_count), .o_overflow (rd_overflow),
		.o_empty (empty), .o_level (level), .o_dropped (dropped)
	);

	dsi3_axil_regs dsi3_axil_regs_i (
		.clk_rst (clk_rst), .i_rst_n (i_rst_n),
		.i_axil_awaddr (s_axil_awaddr), .i_axil_awvalid (s_axil_awvalid),
		.o_axil_awready (s_axil_awready),
		.i_axil_wdata (s_axil_wdata), .i_axil_wstrb (s_axil_wstrb),
		.i_axil_wvalid (s_axil_wvalid), .o_axil_wready (s_axil_wready),
		.o_axil_bresp (s_axil_bresp), .o_axil_bvalid (s_axil_bvalid),
		.i_axil_bready (s_axil_bready),
		.i_axil_araddr (s_axil_araddr), .i_axil_arvalid (s_axil_arvalid),
		.o_axil_arready (s_axil_arready),
		.o_axil_rdata (s_axil_rdata), .o_axil_rresp (s_axil_rresp),
		.o_axil_rvalid (s_axil_rvalid), .i_axil_rready (s_axil_rready),
		.i_rd_data (rd_data), .i_rd_ecc (rd_ecc), .i_rd_count (rd_count),
		.i_rd_overflow (rd_overflow), .i_empty (empty), .i_level (level),
		.i_dropped (dropped), .i_last_count (last_count), .i_last_overflow (last_overflow),
		.i_response_done (response_done), .i_busy (busy),
		.o_enable (enable), .o_start (start), .o_timeout (timeout),
		.o_pop (pop), .o_clear_drop (clear_drop)
	);

endmodule

`default_nettype wire

// ==== dv/tb_dsi3_receiver.sv ====
// Self-checking testbench for the DSI3 receive path, run from the project root
// Records come from dv/dsi3_receiver_patterns.txt; the run stops at the first mismatch
// Symbol gaps are pseudo-random with a fixed seed, so every run is the same
`timescale 1ns/1ps
`default_nettype none

`include "dsi3_params.svh"

module tb_dsi3_receiver;
	import dsi3_pkg::*;

	localparam int HANDSHAKE_LIMIT = 50;
	localparam int POLL_LIMIT = 200;
	localparam logic [1:0] RESP_OKAY = 2'b00;
	typedef logic [`DSI3_AXIL_ADDR_WIDTH-1:0] addr_t;
	typedef logic [`DSI3_AXIL_DATA_WIDTH-1:0] bus_word_t;
	typedef logic [$clog2(`DSI3_FIFO_DEPTH):0] level_t;

	logic clk_rst;
	logic i_rst_n;
	logic symbol_valid;
	logic response_end;
	symbol_t symbol;
	addr_t awaddr;
	addr_t araddr;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	bus_word_t wdata;
	bus_word_t rdata;
	logic [`DSI3_AXIL_DATA_WIDTH/8-1:0] wstrb;
	logic [1:0] bresp, rresp;
	logic [31:0] lfsr;
	logic [63:0] field [5];

	dsi3_receiver_top dsi3_receiver_top_i (
		.clk_rst (clk_rst), .i_rst_n (i_rst_n),
		.i_symbol_valid (symbol_valid), .i_symbol (symbol), .i_response_end (response_end),
		.s_axil_awaddr (awaddr), .s_axil_awvalid (awvalid), .s_axil_awready (awready),
		.s_axil_wdata (wdata), .s_axil_wstrb (wstrb), .s_axil_wvalid (wvalid),
		.s_axil_wready (wready), .s_axil_bresp (bresp), .s_axil_bvalid (bvalid),
		.s_axil_bready (bready), .s_axil_araddr (araddr), .s_axil_arvalid (arvalid),
		.s_axil_arready (arready), .s_axil_rdata (rdata), .s_axil_rresp (rresp),
		.s_axil_rvalid (rvalid), .s_axil_rready (rready)
	);

	always #20 clk_rst = ~clk_rst;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_data(input data_t got, input data_t exp);
		if (got !== exp)
			stop_run($sformatf("ERROR at %0t: data %h, expected %h", $time, got, exp));
	endtask

	task automatic check_ecc(input ecc_t got, input ecc_t exp);
		if (got !== exp)
			stop_run($sformatf("ERROR at %0t: ecc %h, expected %h", $time, got, exp));
	endtask

	task automatic check_count(input symbol_count_t got, input symbol_count_t exp);
		if (got !== exp)
			stop_run($sformatf("ERROR at %0t: symbol count %0d, expected %0d", $time, got, exp));
	endtask

	task automatic check_level(input level_t got, input level_t exp);
		if (got !== exp)
			stop_run($sformatf("ERROR at %0t: FIFO level %0d, expected %0d", $time, got, exp));
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("ERROR at %0t: %s flag %b, expected %b", $time, what, got, exp));
	endtask

	task automatic check_resp(input string what, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
			stop_run($sformatf("ERROR at %0t: %s %b, expected %b", $time, what, got, exp));
	endtask

	// Galois LFSR stepped once per bit taken
	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'hD0000001 : 32'h0);
		end
		return v;
	endfunction

	// Returns 2 ns after a rising edge where all inputs change
	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk_rst);
			#2;
		end
	endtask

	task automatic axil_write(input addr_t addr, input bus_word_t data);
		int n;
		logic aw_seen, w_seen, b_seen;
		awaddr = addr;
		awvalid = 1'b1;
		wdata = data;
		wstrb = '1;
		wvalid = 1'b1;
		n = 0;
		// Readies sampled mid-cycle mean a handshake on the next edge
		while (awvalid || wvalid) begin
			@(negedge clk_rst);
			aw_seen = awvalid && awready;
			w_seen = wvalid && wready;
			idle(1);
			if (aw_seen)
				awvalid = 1'b0;
			if (w_seen)
				wvalid = 1'b0;
			n++;
			if ((awvalid || wvalid) && n > HANDSHAKE_LIMIT)
				stop_run("Timeout: write address or write data was never accepted");
		end
		bready = 1'b1;
		n = 0;
		do begin
			@(negedge clk_rst);
			b_seen = bvalid;
			if (b_seen)
				check_resp("BRESP", bresp, RESP_OKAY);
			idle(1);
			n++;
			if (!b_seen && n > HANDSHAKE_LIMIT)
				stop_run("Timeout: no write response came back");
		end while (!b_seen);
		bready = 1'b0;
	endtask

	task automatic axil_read(input addr_t addr, output bus_word_t data);
		int n;
		logic seen;
		araddr = addr;
		arvalid = 1'b1;
		n = 0;
		do begin
			@(negedge clk_rst);
			seen = arready;
			idle(1);
			n++;
			if (!seen && n > HANDSHAKE_LIMIT)
				stop_run("Timeout: read address was never accepted");
		end while (!seen);
		arvalid = 1'b0;
		rready = 1'b1;
		n = 0;
		do begin
			@(negedge clk_rst);
			seen = rvalid;
			data = rdata;
			if (seen)
				check_resp("RRESP", rresp, RESP_OKAY);
			idle(1);
			n++;
			if (!seen && n > HANDSHAKE_LIMIT)
				stop_run("Timeout: no read data came back");
		end while (!seen);
		rready = 1'b0;
	endtask

	task automatic read_word(input data_t exp_data, input ecc_t exp_ecc);
		bus_word_t r;
		axil_read(`DSI3_ADDR_DATA, r);
		check_data(r[15:0], exp_data);
		check_ecc(r[21:16], exp_ecc);
	endtask

	// Head entry count and overflow, read without popping
	task automatic check_head(input symbol_count_t count);
		bus_word_t r;
		axil_read(`DSI3_ADDR_INFO, r);
		check_count(r[8:0], count);
		check_flag("head overflow", r[9], count > symbol_count_t'(255));
	endtask

	task automatic check_status(input symbol_count_t count, input logic ovf,
			input level_t level, input logic dropped, input logic busy);
		bus_word_t r;
		axil_read(`DSI3_ADDR_STATUS, r);
		check_count(r[24:16], count);
		check_flag("last overflow", r[25], ovf);
		check_flag("empty", r[0], level == '0);
		check_level(r[4:1], level);
		check_flag("dropped", r[5], dropped);
		check_flag("busy", r[6], busy);
	endtask

	task automatic wait_idle();
		bus_word_t r;
		int n;
		n = 0;
		do begin
			axil_read(`DSI3_ADDR_STATUS, r);
			n++;
			if (r[6] && n > POLL_LIMIT)
				stop_run("Timeout: receiver stayed busy, the symbol gap timeout never ended it");
		end while (r[6]);
	endtask

	// Ending code 1 sends an end pulse, 0 waits for the gap timeout and 2 leaves it open
	task automatic send_response(input int nsym, input logic [63:0] pattern, input int ending,
			input logic read_each, input data_t exp_data, input ecc_t exp_ecc);
		for (int i = 0; i < nsym; i++) begin
			// At least one idle cycle so that the start tick clears the count first
			idle(1 + take_bits(2));
			symbol = pattern[63 - 4 * (i % 16) -: 4];
			symbol_valid = 1'b1;
			idle(1);
			symbol_valid = 1'b0;
			// Only words ending at symbols 4 to 256 are stored
			if (read_each && ((i + 1) % 4 == 0) && (i + 1 <= 256)) begin
				idle(2);
				check_head(symbol_count_t'(i + 1));
				read_word(exp_data, exp_ecc);
			end
		end
		if (ending == 1) begin
			response_end = 1'b1;
			idle(1);
			response_end = 1'b0;
			idle(2);
		end else if (ending == 0) begin
			wait_idle();
		end
	endtask

	task automatic skip_line(input int fd);
		int c;
		c = 0;
		while (c != 10 && c != -1)
			c = $fgetc(fd);
	endtask

	task automatic read_fields(input int fd, input int count);
		for (int i = 0; i < count; i++) begin
			if ($fscanf(fd, "%h", field[i]) != 1)
				stop_run("Pattern file record has too few fields");
		end
	endtask

	initial begin
		int fd;
		int c;
		clk_rst = 1'b0;
		i_rst_n = 1'b0;
		symbol_valid = 1'b0;
		symbol = '0;
		response_end = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		lfsr = 32'h809d5634;
		idle(8);
		i_rst_n = 1'b1;
		fd = $fopen("dv/dsi3_receiver_patterns.txt", "r");
		if (fd == 0)
			stop_run("Cannot open dv/dsi3_receiver_patterns.txt");
		c = $fgetc(fd);
		while (c != -1) begin
			case (c)
				"#": skip_line(fd);
				"C": begin
					read_fields(fd, 1);
					axil_write(`DSI3_ADDR_CTRL, bus_word_t'(field[0]));
				end
				"O": begin
					read_fields(fd, 1);
					axil_write(`DSI3_ADDR_TIMEOUT, bus_word_t'(field[0]));
				end
				"S": begin
					read_fields(fd, 3);
					send_response(int'(field[0]), field[2], int'(field[1]), 1'b0, '0, '0);
				end
				"L": begin
					read_fields(fd, 4);
					send_response(int'(field[0]), field[1], 1, 1'b1,
						data_t'(field[2]), ecc_t'(field[3]));
				end
				"W": begin
					read_fields(fd, 2);
					read_word(data_t'(field[0]), ecc_t'(field[1]));
				end
				"T": begin
					read_fields(fd, 5);
					check_status(symbol_count_t'(field[0]), field[1][0],
						level_t'(field[2]), field[3][0], field[4][0]);
				end
				// Whitespace between records
				9, 10, 13, 32: begin
				end
				default: stop_run($sformatf("Unknown record type %c in pattern file", c));
			endcase
			c = $fgetc(fd);
		end
		$fclose(fd);
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+source
source/dsi3_pkg.sv
source/dsi3_word_if.sv
source/ecc_encoder.sv
source/dsi3_receive_control.sv
source/dsi3_receive_data_collect.sv
source/dsi3_rx_fifo.sv
source/dsi3_axil_regs.sv
source/dsi3_receiver_top.sv
dv/tb_dsi3_receiver.sv

// ==== dv/dsi3_receiver_patterns.txt ====
# Records, all values hex: C ctrl | O timeout | S nsym end pattern | W data ecc
# L nsym pattern data ecc (read each word) | T count ovf level dropped busy; end 1 pulse 0 timeout 2 open
O 3e8
# Eight symbols, end pulse
C 3
S 8 1 1234abcd5a0f8001
W 1234 19
W abcd 11
T 8 0 0 0 0
# Six symbols leave a half word, three symbols store nothing
C 3
S 6 1 1234abcd5a0f8001
W 1234 19
W ab00 34
C 3
S 3 1 1234abcd5a0f8001
T 3 0 0 0 0
# Response ended by the gap timeout
O 14
C 3
S 5 0 1234abcd5a0f8001
W 1234 19
W a000 06
T 5 0 0 0 0
# Ten words into the 8-entry FIFO
O 3e8
C 3
S 28 1 1234abcd5a0f8001
T 28 0 8 1 0
W 1234 19
W abcd 11
W 5a0f 1e
W 8001 36
W 1234 19
W abcd 11
W 5a0f 1e
W 8001 36
T 28 0 0 1 0
C 4
T 28 0 0 0 0
# 260 symbols with reads in between
C 3
L 104 1234123412341234 1234 19
T 104 1 0 0 0
# Enable cleared mid-response
C 3
S 2 2 1234abcd5a0f8001
C 0
S 6 2 1234abcd5a0f8001
T 104 1 0 0 0
